// ==== all.f ====
+incdir+verification
hw/sat_num_pkg.sv
hw/sat_xact_pkg.sv
hw/recip_table.sv
hw/unsat_clause_buffer.sv
hw/clause_pick_unit.sv
hw/unsat_clause_selector.sv
verification/tb_unsat_clause_selector.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the selector testbench with Verilator, run it and grade the log.
cd "$(dirname "$0")" || exit 1

TOP=tb_unsat_clause_selector
LOG=sim.log

rm -rf obj_dir "$LOG" build.log

verilator --binary --timing --assert -Wno-fatal -f all.f \
    --top-module "$TOP" -Mdir obj_dir -o sim_bin > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_bin > "$LOG" 2>&1
cat "$LOG"

grep -q "^Finished with no errors$" "$LOG" && echo "PASS" && exit 0 \
    || { echo "FAIL"; exit 1; }

// ==== verification/tb_selector_model.svh ====
////////////////////////////////////////
// reference model for the selector
// testbench. mirrors the clause buffer
// and predicts each select response.
// included inside the testbench module.
////////////////////////////////////////
`ifndef TB_SELECTOR_MODEL_SVH
`define TB_SELECTOR_MODEL_SVH

// buffer contents in slot order.
clause_id_t model_q[$];

function automatic void model_clear();
    model_q.delete();
endfunction

// a push on a full buffer is dropped.
function automatic void model_push(input clause_id_t cid);
    if (model_q.size() < BUFFER_DEPTH) begin
        model_q.push_back(cid);
    end
endfunction

// last entry moves into the hole, an index past the end is ignored.
function automatic void model_remove(input int idx);
    int last;
    if (idx < model_q.size()) begin
        last = model_q.size() - 1;
        model_q[idx] = model_q[last];
        model_q.delete(last);
    end
endfunction

// expected response: slot r mod m, or the empty result for m = 0.
function automatic sel_rsp_t ref_select(input rand_t r);
    sel_rsp_t rsp;
    int m;
    int idx;
    m = model_q.size();
    rsp = '0;
    if (m == 0) begin
        rsp.empty = 1'b1;
    end else begin
        idx = int'(r) % m;
        rsp.index = index_t'(idx);
        rsp.clause_id = model_q[idx];
    end
    return rsp;
endfunction

`endif

// ==== verification/tb_unsat_clause_selector.sv ====
////////////////////////////////////////
// testbench of the unsat clause selector.
// drives updates and four-phase selects
// on the falling edge, checks responses
// against the model, prints a summary.
////////////////////////////////////////
`timescale 1ns/1ps

module tb_unsat_clause_selector;

    import sat_num_pkg::*;
    import sat_xact_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int SEED = 70968;
    // each handshake of the stimulus gets at most 20 cycles.
    localparam int NUM_OPS = 2 + 240 + 90 + 1 + 250 + 12 + 6;
    localparam int CYCLES_PER_OP = 20;

    logic     clk_i;
    logic     rst_n_i;
    logic     sel_req_i;
    sel_req_t sel_req_data_i;
    logic     sel_ack_o;
    sel_rsp_t sel_rsp_o;
    logic     upd_valid_i;
    buf_upd_t upd_i;
    logic     upd_ready_o;
    count_t   count_o;
    logic     dbz_clear_i;
    logic     div_by_zero_o;
    int       errors;
    logic     ack_seen;
    sel_rsp_t exp_q[$];

    `include "tb_selector_model.svh"

    unsat_clause_selector i_dut (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .sel_req_i      (sel_req_i),
        .sel_req_data_i (sel_req_data_i),
        .sel_ack_o      (sel_ack_o),
        .sel_rsp_o      (sel_rsp_o),
        .upd_valid_i    (upd_valid_i),
        .upd_i          (upd_i),
        .upd_ready_o    (upd_ready_o),
        .count_o        (count_o),
        .dbz_clear_i    (dbz_clear_i),
        .div_by_zero_o  (div_by_zero_o)
    );

    initial clk_i = 1'b0;
    always #5 clk_i = ~clk_i;

    task automatic apply_reset();
        rst_n_i = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk_i);
        rst_n_i = 1'b1;
        model_clear();
    endtask

    // one valid/ready update held until the buffer takes it.
    task automatic send_update(input logic op, input clause_id_t cid, input index_t idx);
        @(negedge clk_i);
        upd_valid_i = 1'b1;
        upd_i = '{op: op, clause_id: cid, index: idx};
        while (!upd_ready_o) @(negedge clk_i);
        @(negedge clk_i);
        upd_valid_i = 1'b0;
        if (op == OP_PUSH) begin
            model_push(cid);
        end else begin
            model_remove(int'(idx));
        end
        if (count_o !== count_t'(model_q.size())) begin
            $display("** Error at %0t: count %0d, expected %0d", $time, count_o, model_q.size());
            errors++;
        end
    endtask

    // full four-phase select with an optional push held valid meanwhile.
    task automatic run_select(input rand_t r, input bit hold_push, input clause_id_t cid);
        int     cycles;
        count_t cnt_before;
        @(negedge clk_i);
        exp_q.push_back(ref_select(r));
        cnt_before = count_t'(model_q.size());
        sel_req_i = 1'b1;
        sel_req_data_i.rand_word = r;
        cycles = 0;
        do begin
            @(negedge clk_i);
            cycles++;
            if (hold_push && cycles == 1) begin
                upd_valid_i = 1'b1;
                upd_i = '{op: OP_PUSH, clause_id: cid, index: '0};
            end
            if (upd_ready_o !== 1'b0 || count_o !== cnt_before) begin
                $display("** Error at %0t: update side not stalled during a select", $time);
                errors++;
            end
        end while (!sel_ack_o && cycles < CYCLES_PER_OP);
        if (!sel_ack_o) begin
            $display("select with r=%0d was never acknowledged", r);
            errors++;
        end else if (cycles - 1 != 5) begin
            $display("** Error at %0t: ack after %0d cycles, expected 5", $time, cycles - 1);
            errors++;
        end
        sel_req_i = 1'b0;
        cycles = 0;
        do begin
            @(negedge clk_i);
            cycles++;
        end while (sel_ack_o && cycles < CYCLES_PER_OP);
        // held push is applied on the edge after ack drops.
        if (upd_ready_o !== 1'b1 || count_o !== cnt_before) begin
            $display("** Error at %0t: update side wrong after ack dropped", $time);
            errors++;
        end
        if (hold_push) begin
            @(negedge clk_i);
            upd_valid_i = 1'b0;
            model_push(cid);
            if (count_o !== count_t'(model_q.size())) begin
                $display("** Error at %0t: held push gave count %0d", $time, count_o);
                errors++;
            end
        end
    endtask

    // ceil(2^32/m) must satisfy r*m >= 2^32 > (r-1)*m.
    task automatic check_recip();
        longint unsigned r;
        for (longint unsigned m = 2; m <= BUFFER_DEPTH; m++) begin
            r = longint'(recip_of(int'(m)));
            if (r * m < (64'd1 << 32) || (r - 1) * m >= (64'd1 << 32)) begin
                $display("** Error at %0t: reciprocal of %0d is %0h", $time, m, r);
                errors++;
            end
        end
    endtask

    // compares each response on the first falling edge with ack high.
    always @(negedge clk_i) begin
        sel_rsp_t exp;
        if (sel_ack_o && !ack_seen) begin
            if (exp_q.size() == 0) begin
                $display("an acknowledge arrived with no select outstanding");
                errors++;
            end else begin
                exp = exp_q.pop_front();
                if (sel_rsp_o !== exp) begin
                    $display("** Error at %0t: rsp id %0d idx %0d empty %0b, exp %0d %0d %0b",
                             $time, sel_rsp_o.clause_id, sel_rsp_o.index, sel_rsp_o.empty,
                             exp.clause_id, exp.index, exp.empty);
                    errors++;
                end
            end
        end
        ack_seen = sel_ack_o;
    end

    initial begin
        repeat (NUM_OPS * CYCLES_PER_OP + RESET_CYCLES) @(posedge clk_i);
        $display("timeout, the stimulus did not finish in time");
        $display("Finished with errors");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        errors = 0;
        ack_seen = 1'b0;
        rst_n_i = 1'b0;
        sel_req_i = 1'b0;
        sel_req_data_i = '0;
        upd_valid_i = 1'b0;
        upd_i = '0;
        dbz_clear_i = 1'b0;
        check_recip();
        apply_reset();
        @(negedge clk_i);
        if (count_o !== '0 || div_by_zero_o !== 1'b0 || sel_ack_o !== 1'b0
            || upd_ready_o !== 1'b1) begin
            $display("** Error at %0t: outputs not in their reset state", $time);
            errors++;
        end
        // an empty buffer select sets the sticky flag and the host clears it.
        run_select(rand_t'($urandom), 1'b0, '0);
        if (div_by_zero_o !== 1'b1) begin
            $display("** Error at %0t: divide by zero flag not set", $time);
            errors++;
        end
        @(negedge clk_i);
        dbz_clear_i = 1'b1;
        @(negedge clk_i);
        dbz_clear_i = 1'b0;
        if (div_by_zero_o !== 1'b0) begin
            $display("** Error at %0t: divide by zero flag not cleared", $time);
            errors++;
        end
        repeat (40) send_update(OP_PUSH, clause_id_t'($urandom), '0);
        repeat (200) run_select(rand_t'($urandom), 1'b0, '0);
        if (div_by_zero_o !== 1'b0) begin
            $display("** Error at %0t: divide by zero flag set with entries present", $time);
            errors++;
        end
        repeat (30) begin
            send_update(OP_REMOVE, '0, index_t'($urandom % model_q.size()));
            repeat (2) run_select(rand_t'($urandom), 1'b0, '0);
        end
        run_select(rand_t'($urandom), 1'b1, clause_id_t'($urandom));
        // fill up and then push once more.
        while (model_q.size() < BUFFER_DEPTH) begin
            send_update(OP_PUSH, clause_id_t'($urandom), '0);
        end
        send_update(OP_PUSH, clause_id_t'($urandom), '0);
        run_select(16'd0, 1'b0, '0);
        run_select(16'hffff, 1'b0, '0);
        run_select(rand_t'($urandom), 1'b0, '0);
        repeat (6) send_update(OP_REMOVE, '0, index_t'($urandom % model_q.size()));
        send_update(OP_REMOVE, '0, index_t'(model_q.size()));
        send_update(OP_REMOVE, '0, index_t'(BUFFER_DEPTH - 1));
        repeat (3) run_select(rand_t'($urandom), 1'b0, '0);
        // with a single entry every word maps to slot 0.
        apply_reset();
        send_update(OP_PUSH, clause_id_t'($urandom), '0);
        run_select(16'd0, 1'b0, '0);
        run_select(16'hffff, 1'b0, '0);
        run_select(rand_t'($urandom), 1'b0, '0);
        repeat (3) @(negedge clk_i);
        if (exp_q.size() != 0) begin
            $display("%0d selects were never answered", exp_q.size());
            errors++;
        end
        $display("checks done, %0d errors", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== hw/unsat_clause_selector.sv ====
////////////////////////////////////////
// top of the unsat clause selector.
// buffer and reciprocal table both take
// the count, the pick unit joins them.
// host side is a four-phase select plus
// a valid/ready update port.
////////////////////////////////////////
`timescale 1ns/1ps

module unsat_clause_selector (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   sel_req_i,
    input  sat_xact_pkg::sel_req_t sel_req_data_i,
    output logic                   sel_ack_o,
    output sat_xact_pkg::sel_rsp_t sel_rsp_o,
    input  logic                   upd_valid_i,
    input  sat_xact_pkg::buf_upd_t upd_i,
    output logic                   upd_ready_o,
    output sat_num_pkg::count_t    count_o,
    input  logic                   dbz_clear_i,
    output logic                   div_by_zero_o
);

    import sat_num_pkg::*;

    // table lookup side.
    logic       tbl_en;
    count_t     tbl_m;
    recip_t     recip;
    // buffer read side.
    index_t     rd_idx;
    clause_id_t rd_clause;
    // high from acceptance until ack drops.
    logic       busy;

    // live count goes out and into the pick unit.
    unsat_clause_buffer i_buffer (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .upd_valid_i (upd_valid_i),
        .upd_i       (upd_i),
        .busy_i      (busy),
        .upd_ready_o (upd_ready_o),
        .count_o     (count_o),
        .rd_idx_i    (rd_idx),
        .rd_clause_o (rd_clause)
    );

    recip_table i_recip (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .en_i        (tbl_en),
        .m_i         (tbl_m),
        .recip_o     (recip),
        .dbz_clear_i (dbz_clear_i),
        .dbz_o       (div_by_zero_o)
    );

    clause_pick_unit i_pick (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .sel_req_i      (sel_req_i),
        .sel_req_data_i (sel_req_data_i),
        .sel_ack_o      (sel_ack_o),
        .sel_rsp_o      (sel_rsp_o),
        .count_i        (count_o),
        .tbl_en_o       (tbl_en),
        .tbl_m_o        (tbl_m),
        .recip_i        (recip),
        .rd_idx_o       (rd_idx),
        .rd_clause_i    (rd_clause),
        .busy_o         (busy)
    );

endmodule

// ==== hw/clause_pick_unit.sv ====
////////////////////////////////////////
// four-phase select controller. maps a
// random word to r mod m with the table
// reciprocal, then fetches the clause id.
// ack rises five edges after acceptance.
////////////////////////////////////////
`timescale 1ns/1ps

module clause_pick_unit (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    sel_req_i,
    input  sat_xact_pkg::sel_req_t  sel_req_data_i,
    output logic                    sel_ack_o,
    output sat_xact_pkg::sel_rsp_t  sel_rsp_o,
    input  sat_num_pkg::count_t     count_i,
    output logic                    tbl_en_o,
    output sat_num_pkg::count_t     tbl_m_o,
    input  sat_num_pkg::recip_t     recip_i,
    output sat_num_pkg::index_t     rd_idx_o,
    input  sat_num_pkg::clause_id_t rd_clause_i,
    output logic                    busy_o
);

    import sat_num_pkg::*;
    import sat_xact_pkg::*;

    pick_state_t state_q;
    pick_state_t state_d;
    logic        ack_q;
    logic        ack_d;
    logic        accept;
    logic        snap_empty;
    rand_t       rand_q;
    count_t      cnt_q;
    rand_t       quot_q;
    index_t      idx_q;
    sel_rsp_t    rsp_q;
    logic [RAND_W+RECIP_W-1:0] prod;
    logic [RAND_W+CNT_W-1:0]   qm;
    rand_t       m_ext;
    rand_t       rem_raw;
    rand_t       rem_fix;

    // ack is always low in IDLE, so a request here is a fresh one.
    assign accept = (state_q == IDLE) && sel_req_i;
    assign snap_empty = (cnt_q == '0);

    // quotient estimate, upper bits of r times 2^32/m.
    assign prod = rand_q * recip_i;
    // remainder from the registered quotient.
    assign qm = quot_q * cnt_q;
    assign m_ext = {{(RAND_W-CNT_W){1'b0}}, cnt_q};
    assign rem_raw = rand_q - qm[RAND_W-1:0];
    // one correction step, covers the saturated m = 1 entry.
    assign rem_fix = (rem_raw >= m_ext) ? (rem_raw - m_ext) : rem_raw;

    always_comb begin
        state_d = state_q;
        ack_d = ack_q;
        case (state_q)
            IDLE:   if (accept) state_d = LOOKUP;
            LOOKUP: state_d = MULT;
            MULT:   state_d = REDUCE;
            REDUCE: state_d = FETCH;
            FETCH:  state_d = ACK;
            ACK: begin
                if (!ack_q) begin
                    ack_d = 1'b1;
                end else if (!sel_req_i) begin
                    // host released the request, close the handshake.
                    ack_d = 1'b0;
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            ack_q <= 1'b0;
        end else begin
            state_q <= state_d;
            ack_q <= ack_d;
        end
    end

    // datapath registers, each loaded in its own step.
    always_ff @(posedge clk_i) begin
        if (accept) begin
            rand_q <= sel_req_data_i.rand_word;
            cnt_q <= count_i;
        end
        if (state_q == MULT) begin
            quot_q <= prod[RAND_W+RECIP_W-1:RECIP_W];
        end
        if (state_q == REDUCE) begin
            idx_q <= snap_empty ? '0 : rem_fix[IDX_W-1:0];
        end
        if ((state_q == ACK) && !ack_q) begin
            // empty result does not use the read data.
            rsp_q.clause_id <= snap_empty ? '0 : rd_clause_i;
            rsp_q.index <= idx_q;
            rsp_q.empty <= snap_empty;
        end
    end

    // table is read even for m = 0 so the flag records it.
    assign tbl_en_o = (state_q == LOOKUP);
    assign tbl_m_o = cnt_q;
    assign rd_idx_o = idx_q;
    assign busy_o = (state_q != IDLE);
    assign sel_ack_o = ack_q;
    assign sel_rsp_o = rsp_q;

    // table reciprocal and single correction give a true remainder.
    a_rem_below_m: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ((state_q == REDUCE) && !snap_empty) |-> (rem_fix < m_ext))
        else $error("clause_pick_unit: remainder %0d not below m %0d", rem_fix, cnt_q);

endmodule

// ==== hw/unsat_clause_buffer.sv ====
////////////////////////////////////////
// store of unsatisfied clause ids.
// push appends, remove swaps in the last
// entry. count and a one cycle read port
// feed the pick unit.
////////////////////////////////////////
`timescale 1ns/1ps

module unsat_clause_buffer (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    upd_valid_i,
    input  sat_xact_pkg::buf_upd_t  upd_i,
    input  logic                    busy_i,
    output logic                    upd_ready_o,
    output sat_num_pkg::count_t     count_o,
    input  sat_num_pkg::index_t     rd_idx_i,
    output sat_num_pkg::clause_id_t rd_clause_o
);

    import sat_num_pkg::*;
    import sat_xact_pkg::*;

    clause_id_t mem [BUFFER_DEPTH];
    count_t     count_q;
    count_t     last_cnt;
    index_t     tail_idx;
    index_t     last_idx;
    clause_id_t rd_clause_q;
    logic       fire;
    logic       full;
    logic       do_push;
    logic       do_remove;

    // updates stall while a selection is in flight.
    assign upd_ready_o = !busy_i;
    assign fire = upd_valid_i && upd_ready_o;

    assign full = (count_q == count_t'(BUFFER_DEPTH));
    assign last_cnt = count_q - count_t'(1);
    // next free slot, only used when not full.
    assign tail_idx = count_q[IDX_W-1:0];
    assign last_idx = last_cnt[IDX_W-1:0];

    // push on a full buffer is dropped.
    assign do_push = fire && (upd_i.op == OP_PUSH) && !full;
    // remove of a slot past the end is dropped.
    assign do_remove = fire && (upd_i.op == OP_REMOVE)
                       && (count_t'(upd_i.index) < count_q);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
        end else if (do_push) begin
            count_q <= count_q + count_t'(1);
        end else if (do_remove) begin
            count_q <= last_cnt;
        end
    end

    // storage has no reset, entries at or past count are don't care.
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[tail_idx] <= upd_i.clause_id;
        end else if (do_remove) begin
            // last entry fills the hole, removing the last one is a self copy.
            mem[upd_i.index] <= mem[last_idx];
        end
    end

    // registered read for the pick unit.
    always_ff @(posedge clk_i) begin
        rd_clause_q <= mem[rd_idx_i];
    end

    assign count_o = count_q;
    assign rd_clause_o = rd_clause_q;

    // count can never run past capacity over any update sequence.
    a_count_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        count_q <= count_t'(BUFFER_DEPTH))
        else $error("unsat_clause_buffer: count %0d above depth", count_q);

endmodule

// ==== hw/recip_table.sv ====
////////////////////////////////////////
// reciprocal ROM for the modulo step.
// entry m-1 holds ceil(2^32/m), read one
// cycle after en_i. a read of m = 0 sets
// a sticky flag the host clears.
////////////////////////////////////////
`timescale 1ns/1ps

module recip_table (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                en_i,
    input  sat_num_pkg::count_t m_i,
    output sat_num_pkg::recip_t recip_o,
    input  logic                dbz_clear_i,
    output logic                dbz_o
);

    import sat_num_pkg::*;

    recip_t rom [BUFFER_DEPTH];
    count_t m_dec;
    index_t addr;
    recip_t recip_q;
    logic   dbz_q;

    // constant table, entry i is the reciprocal of i+1.
    for (genvar g = 0; g < BUFFER_DEPTH; g++) begin : g_rom
        assign rom[g] = recip_of(g + 1);
    end

    // m of 0 falls back onto entry 0.
    assign m_dec = m_i - count_t'(1);
    assign addr = (m_i == '0) ? '0 : m_dec[IDX_W-1:0];

    // output is zero on cycles without a read.
    always_ff @(posedge clk_i) begin
        recip_q <= en_i ? rom[addr] : '0;
    end

    // sticky divide by zero flag, a new set beats the clear.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            dbz_q <= 1'b0;
        end else if (en_i && (m_i == '0)) begin
            dbz_q <= 1'b1;
        end else if (dbz_clear_i) begin
            dbz_q <= 1'b0;
        end
    end

    assign recip_o = recip_q;
    assign dbz_o = dbz_q;

    // the count snapshot from the pick unit stays in table range.
    a_m_in_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        m_i <= count_t'(BUFFER_DEPTH))
        else $error("recip_table: m_i %0d above buffer depth", m_i);

endmodule

// ==== hw/sat_xact_pkg.sv ====
////////////////////////////////////////
// transaction formats of the unsat
// clause selector: select request and
// response, buffer update and the pick
// FSM states.
////////////////////////////////////////
package sat_xact_pkg;

    import sat_num_pkg::*;

    // update opcodes carried in buf_upd_t.op.
    localparam logic OP_PUSH = 1'b1;
    localparam logic OP_REMOVE = 1'b0;

    // select request, held stable while sel_req_i is high.
    typedef struct packed {
        rand_t rand_word;
    } sel_req_t;

    // select result, valid while sel_ack_o is high.
    // empty set means the buffer had no entries, id and index are zero.
    typedef struct packed {
        clause_id_t clause_id;
        index_t     index;
        logic       empty;
    } sel_rsp_t;

    // buffer update, clause_id used by push and index by remove.
    typedef struct packed {
        logic       op;
        clause_id_t clause_id;
        index_t     index;
    } buf_upd_t;

    // pick FSM, one state per pipeline step of a selection.
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MULT,
        REDUCE,
        FETCH,
        ACK
    } pick_state_t;

endpackage

// ==== hw/sat_num_pkg.sv ====
////////////////////////////////////////
// numeric formats of the unsat clause
// selector: widths, typedefs and the
// reciprocal used for the modulo step.
// import it where these types are used.
////////////////////////////////////////
package sat_num_pkg;

    // buffer capacity in clause ids.
    localparam int BUFFER_DEPTH = 256;
    // count runs 0 to BUFFER_DEPTH, so one bit more than an index.
    localparam int CNT_W = $clog2(BUFFER_DEPTH + 1);
    localparam int IDX_W = $clog2(BUFFER_DEPTH);
    localparam int CLAUSE_W = 12;
    localparam int RAND_W = 16;
    // reciprocal is all fraction bits.
    localparam int RECIP_W = 32;

    typedef logic [CLAUSE_W-1:0] clause_id_t;
    typedef logic [CNT_W-1:0] count_t;
    typedef logic [IDX_W-1:0] index_t;
    typedef logic [RAND_W-1:0] rand_t;
    typedef logic [RECIP_W-1:0] recip_t;

    // ceil(2^32 / m), evaluated at elaboration.
    // m of 1 would need 33 bits, it saturates to all ones.
    // the single correction step in the pick unit absorbs that.
    function automatic recip_t recip_of(input int unsigned m);
        longint unsigned num;
        longint unsigned quo;
        if (m == 0) begin
            return '0;
        end
        num = (64'd1 << RECIP_W) + 64'(m) - 64'd1;
        quo = num / 64'(m);
        if (quo >= (64'd1 << RECIP_W)) begin
            return '1;
        end
        return recip_t'(quo);
    endfunction

endpackage
